/* Makefile */
# Verilator build and run of the framed string link testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_string_handle
FILELIST  ?= uart_string_handle.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Verification passed
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the output is shown and then searched for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* rtl/uart_rx.sv */
// ================================================
// 8N1 UART deserializer with start bit check and
// mid-bit sampling, one valid pulse per byte
// ================================================
`timescale 1ns/10ps
`default_nettype none

`include "uart_string_defines.svh"

module uart_rx (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        rx,
	output uart_string_pkg::uart_byte_t rx_data,
	output logic                        rx_vld
);
	import uart_string_pkg::*;

	localparam logic [15:0] bit_last = 16'(`USH_CLKS_PER_BIT - 1);
	localparam logic [15:0] bit_half = 16'(`USH_CLKS_PER_BIT / 2 - 1);
	localparam logic [3:0]  stop_idx = 4'd9;

	logic       rx_sync1;
	logic       rx_sync2;
	logic       rx_prev;
	logic       rx_fall;
	logic       busy;
	logic [3:0] bit_idx;
	logic [15:0] bit_cnt;
	logic       sample;
	uart_byte_t shift_reg;

	// two flop synchronizer plus one for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync1 <= 1'b1;
			rx_sync2 <= 1'b1;
			rx_prev  <= 1'b1;
		end else begin
			rx_sync1 <= rx;
			rx_sync2 <= rx_sync1;
			rx_prev  <= rx_sync2;
		end
	end

	assign rx_fall = rx_prev & ~rx_sync2;

	// start bit confirm at half period, later bits a full period on
	assign sample = busy && ((bit_idx == 4'd0) ? (bit_cnt == bit_half) :
		(bit_cnt == bit_last));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			bit_idx <= 4'd0;
			bit_cnt <= 16'd0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			if (!busy) begin
				bit_idx <= 4'd0;
				bit_cnt <= 16'd0;
				busy    <= rx_fall;
			end else if (sample) begin
				bit_cnt <= 16'd0;
				if (bit_idx == 4'd0 && rx_sync2) begin
					// glitch, line went back high
					busy <= 1'b0;
				end else if (bit_idx == stop_idx) begin
					busy   <= 1'b0;
					// framing error drops the byte
					rx_vld <= rx_sync2;
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				bit_cnt <= bit_cnt + 16'd1;
			end
		end
	end

	// data arrives LSB first
	always_ff @(posedge sys_clk) begin
		if (sample && bit_idx != 4'd0 && bit_idx != stop_idx) begin
			shift_reg <= {rx_sync2, shift_reg[7:1]};
		end
	end

	assign rx_data = shift_reg;

endmodule

`default_nettype wire

/* rtl/uart_string_defines.svh */
// ================================================
// shared build-time constants for the framed
// string link: UART bit period, payload capacity
// and the receive frame timeout
// ================================================

`ifndef UART_STRING_DEFINES_SVH
`define UART_STRING_DEFINES_SVH

// system clocks per UART bit
// 16 keeps simulation short, raise for a real baud rate
`define USH_CLKS_PER_BIT 16

// payload capacity of one frame in bytes
`define USH_MAX_BYTES 128

// clocks a receive frame may stay open
// about 1 ms at 50 MHz
`define USH_RX_TIMEOUT 50000

`endif

/* rtl/uart_string_handle.sv */
// ================================================
// framed string link top level: transmit framer,
// receive deframer with idle timeout, and the two
// 8N1 engines underneath
// ================================================
`timescale 1ns/10ps
`default_nettype none

`include "uart_string_defines.svh"

module uart_string_handle (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  uart_string_pkg::ush_string_t tx_msg,
	input  logic                         tx_req,
	output logic                         tx_busy,
	output logic                         tx_done,
	output uart_string_pkg::ush_string_t rx_msg,
	output logic                         rx_busy,
	output logic                         rx_done,
	input  logic                         uart_rx_port,
	output logic                         uart_tx_port
);
	import uart_string_pkg::*;

	// frame delimiters
	localparam uart_byte_t open_char  = 8'h7b;
	localparam uart_byte_t close_char = 8'h7d;

	localparam int unsigned idx_w  = $clog2(`USH_MAX_BYTES);
	localparam int unsigned wait_w = $clog2(`USH_RX_TIMEOUT + 1);
	localparam logic [7:0] max_len = 8'(`USH_MAX_BYTES);
	localparam logic [wait_w-1:0] wait_last = wait_w'(`USH_RX_TIMEOUT - 1);

	// transmit side
	tx_state_e   tx_state;
	ush_string_t tx_buf;
	logic [7:0]  tx_idx;
	logic        uart_tx_req;
	uart_byte_t  uart_tx_data;
	logic        uart_tx_done;
	logic        tx_start;

	// receive side
	rx_state_e   rx_state;
	uart_byte_t  uart_rx_data;
	logic        uart_rx_vld;
	logic        rx_open_byte;
	logic        rx_close_byte;
	logic        rx_other_byte;
	logic [wait_w-1:0] rx_wait_cnt;
	logic        rx_timeout;
	logic [idx_w-1:0] rx_idx;
	logic [idx_w-1:0] rx_idx_next;

	assign tx_start = (tx_state == tx_idle) && tx_req && (tx_msg.length != 8'd0);

	assign tx_busy = (tx_state != tx_idle);
	assign tx_done = (tx_state == tx_finish);
	assign rx_busy = (rx_state != rx_idle);
	assign rx_done = (rx_state == rx_finish);

	// transmit framer FSM, each step waits for the engine's done
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= tx_idle;
		end else begin
			case (tx_state)
				tx_idle:
					if (tx_start)
						tx_state <= tx_open1;
				tx_open1:
					if (uart_tx_done)
						tx_state <= tx_open2;
				tx_open2:
					if (uart_tx_done)
						tx_state <= tx_content;
				tx_content:
					if (uart_tx_done && tx_idx == tx_buf.length)
						tx_state <= tx_close1;
				tx_close1:
					if (uart_tx_done)
						tx_state <= tx_close2;
				tx_close2:
					if (uart_tx_done)
						tx_state <= tx_finish;
				default:
					tx_state <= tx_idle;
			endcase
		end
	end

	// byte requests to the serializer
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			uart_tx_req <= 1'b0;
			tx_idx      <= 8'd0;
		end else begin
			uart_tx_req <= 1'b0;
			if (tx_start) begin
				uart_tx_req <= 1'b1;
				tx_idx      <= 8'd0;
			end else if (uart_tx_done) begin
				// nothing more to send once the second close is out
				uart_tx_req <= (tx_state != tx_close2);
				if (tx_state == tx_open2 ||
					(tx_state == tx_content && tx_idx != tx_buf.length)) begin
					tx_idx <= tx_idx + 8'd1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_start) begin
			tx_buf       <= tx_msg;
			uart_tx_data <= open_char;
		end else if (uart_tx_done) begin
			case (tx_state)
				tx_open1:
					uart_tx_data <= open_char;
				tx_open2:
					uart_tx_data <= tx_buf.data[tx_idx[idx_w-1:0]];
				tx_content:
					if (tx_idx != tx_buf.length)
						uart_tx_data <= tx_buf.data[tx_idx[idx_w-1:0]];
					else
						uart_tx_data <= close_char;
				default:
					uart_tx_data <= close_char;
			endcase
		end
	end

	// receive byte classes
	assign rx_open_byte  = uart_rx_vld && (uart_rx_data == open_char);
	assign rx_close_byte = uart_rx_vld && (uart_rx_data == close_char);
	assign rx_other_byte = uart_rx_vld && (uart_rx_data != close_char);

	// an open frame that goes quiet too long is abandoned
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_wait_cnt <= '0;
		else if (rx_state == rx_idle)
			rx_wait_cnt <= '0;
		else if (!rx_timeout)
			rx_wait_cnt <= rx_wait_cnt + 1'b1;
	end

	assign rx_timeout = (rx_wait_cnt == wait_last);

	// receive deframer FSM
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= rx_idle;
		end else if (rx_timeout) begin
			rx_state <= rx_idle;
		end else begin
			case (rx_state)
				rx_idle:
					if (rx_open_byte)
						rx_state <= rx_open1;
				rx_open1:
					// anything but a second open restarts the hunt
					if (rx_open_byte)
						rx_state <= rx_open2;
					else if (uart_rx_vld)
						rx_state <= rx_idle;
				rx_open2:
					rx_state <= rx_content;
				rx_content:
					if (rx_close_byte)
						rx_state <= rx_close1;
				rx_close1:
					if (rx_close_byte)
						rx_state <= rx_close2;
					else if (uart_rx_vld)
						rx_state <= rx_content;
				rx_close2:
					rx_state <= rx_finish;
				default:
					rx_state <= rx_idle;
			endcase
		end
	end

	assign rx_idx      = rx_msg.length[idx_w-1:0];
	assign rx_idx_next = rx_idx + 1'b1;

	// payload store, bytes past capacity are dropped
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_msg <= '0;
		end else if (rx_state == rx_open2) begin
			rx_msg.length <= 8'd0;
		end else if (rx_state == rx_content && rx_other_byte) begin
			if (rx_msg.length < max_len) begin
				rx_msg.data[rx_idx] <= uart_rx_data;
				rx_msg.length       <= rx_msg.length + 8'd1;
			end
		end else if (rx_state == rx_close1 && rx_other_byte) begin
			// lone close brace was payload after all
			if (rx_msg.length < max_len) begin
				rx_msg.data[rx_idx] <= close_char;
				rx_msg.length       <= rx_msg.length + 8'd1;
			end
			if (rx_msg.length < max_len - 8'd1) begin
				rx_msg.data[rx_idx_next] <= uart_rx_data;
				rx_msg.length            <= rx_msg.length + 8'd2;
			end
		end
	end

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (uart_tx_data),
		.tx_req    (uart_tx_req),
		.tx        (uart_tx_port),
		.tx_done   (uart_tx_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_data   (uart_rx_data),
		.rx_vld    (uart_rx_vld)
	);

endmodule

`default_nettype wire

/* rtl/uart_string_pkg.sv */
// ================================================
// types for the framed string link: UART byte,
// transmit and receive frame states, string struct
// ================================================
`default_nettype none

`include "uart_string_defines.svh"

package uart_string_pkg;

	// one UART character
	typedef logic [7:0] uart_byte_t;

	// transmit framer states
	typedef enum logic [2:0] {
		tx_idle,
		tx_open1,
		tx_open2,
		tx_content,
		tx_close1,
		tx_close2,
		tx_finish
	} tx_state_e;

	// receive deframer states
	typedef enum logic [2:0] {
		rx_idle,
		rx_open1,
		rx_open2,
		rx_content,
		rx_close1,
		rx_close2,
		rx_finish
	} rx_state_e;

	// byte 0 sits in the lowest bits of data
	typedef struct packed {
		uart_byte_t [`USH_MAX_BYTES-1:0] data;
		logic [7:0]                      length;
	} ush_string_t;

endpackage

`default_nettype wire

/* rtl/uart_tx.sv */
// ================================================
// 8N1 UART serializer, started by a request pulse,
// ends each character with a done pulse
// ================================================
`timescale 1ns/10ps
`default_nettype none

`include "uart_string_defines.svh"

module uart_tx (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  uart_string_pkg::uart_byte_t tx_data,
	input  logic                        tx_req,
	output logic                        tx,
	output logic                        tx_done
);
	import uart_string_pkg::*;

	localparam logic [15:0] bit_last = 16'(`USH_CLKS_PER_BIT - 1);
	// index 0 is the start bit, 1..8 data, 9 stop
	localparam logic [3:0] stop_idx = 4'd9;

	logic       busy;
	logic [3:0] bit_idx;
	logic [15:0] bit_cnt;
	uart_byte_t shift_reg;

	// bit timing and line drive
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			bit_idx <= 4'd0;
			bit_cnt <= 16'd0;
			tx      <= 1'b1;
		end else if (!busy) begin
			bit_idx <= 4'd0;
			bit_cnt <= 16'd0;
			if (tx_req) begin
				busy <= 1'b1;
				tx   <= 1'b0;
			end else begin
				tx <= 1'b1;
			end
		end else if (bit_cnt == bit_last) begin
			bit_cnt <= 16'd0;
			if (bit_idx == stop_idx) begin
				busy <= 1'b0;
				tx   <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 4'd1;
				// after the last data bit comes the stop bit
				tx <= (bit_idx == 4'd8) ? 1'b1 : shift_reg[0];
			end
		end else begin
			bit_cnt <= bit_cnt + 16'd1;
		end
	end

	// data bits go out LSB first
	always_ff @(posedge sys_clk) begin
		if (!busy && tx_req) begin
			shift_reg <= tx_data;
		end else if (busy && bit_cnt == bit_last && bit_idx < 4'd8) begin
			shift_reg <= {1'b0, shift_reg[7:1]};
		end
	end

	// last clock of the stop bit
	assign tx_done = busy && (bit_idx == stop_idx) && (bit_cnt == bit_last);

endmodule

`default_nettype wire

/* uart_string_handle.f */
+incdir+rtl
rtl/uart_string_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_string_handle.sv
verif/tb_uart_string_handle.sv

/* verif/tb_uart_string_handle.sv */
// ================================================
// testbench for the framed string link: case table,
// serial driver, serial monitor, compare tasks
// ================================================
`timescale 1ns/10ps
`default_nettype none

`include "uart_string_defines.svh"

module tb_uart_string_handle;
	import uart_string_pkg::*;

	localparam int cpb = `USH_CLKS_PER_BIT;
	localparam int num_cases = 8;
	localparam uart_byte_t open_char  = 8'h7b;
	localparam uart_byte_t close_char = 8'h7d;

	typedef enum logic [1:0] {case_tx, case_rx, case_rx_stall} case_kind_e;

	logic        sys_clk;
	logic        sys_rst_n;
	ush_string_t tx_msg;
	logic        tx_req;
	logic        tx_busy;
	logic        tx_done;
	ush_string_t rx_msg;
	logic        rx_busy;
	logic        rx_done;
	logic        uart_rx_port;
	logic        uart_tx_port;

	case_kind_e case_kind [num_cases];
	string      case_stim [num_cases];
	string      case_exp [num_cases];
	int         tx_done_cnt = 0;
	int         rx_done_cnt = 0;

	uart_string_handle u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_msg       (rx_msg),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// done pulses counted where outputs are settled
	always @(negedge sys_clk) begin
		if (tx_done === 1'b1)
			tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done === 1'b1)
			rx_done_cnt <= rx_done_cnt + 1;
	end

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns: %s did not happen in time", $time, what);
		$display("Verification failed");
		$fatal(1, "stopped on timeout");
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("%s is 0x%02h, expected 0x%02h", what, got, exp));
	endtask

	// whole also compares the bytes past the length
	task automatic check_string(input ush_string_t got, input ush_string_t exp, input bit whole,
		input string what);
		if (got.length !== exp.length)
			report_error($sformatf("%s length is %0d, expected %0d", what, got.length, exp.length));
		for (int i = 0; i < int'(exp.length); i++) begin
			if (got.data[i] !== exp.data[i])
				report_error($sformatf("%s byte %0d is 0x%02h, expected 0x%02h", what, i,
					got.data[i], exp.data[i]));
		end
		if (whole && got !== exp)
			report_error($sformatf("%s differs beyond its length", what));
	endtask

	function automatic ush_string_t make_string(input string s);
		ush_string_t m;
		m = '0;
		for (int i = 0; i < s.len(); i++)
			m.data[i] = s[i];
		m.length = 8'(s.len());
		return m;
	endfunction

	task automatic set_case(input int idx, input case_kind_e kind, input string stim,
		input string exp_s);
		case_kind[idx] = kind;
		case_stim[idx] = stim;
		case_exp[idx]  = exp_s;
	endtask

	// one UART bit held for exactly cpb clocks
	task automatic drive_bit(input logic v);
		@(posedge sys_clk);
		#1 uart_rx_port = v;
		repeat (cpb - 1) @(posedge sys_clk);
	endtask

	task automatic send_serial_string(input string s);
		uart_byte_t b;
		int gap;
		for (int i = 0; i < s.len(); i++) begin
			b = s[i];
			gap = int'($urandom % 6);
			repeat (gap) @(posedge sys_clk);
			drive_bit(1'b0);
			for (int k = 0; k < 8; k++)
				drive_bit(b[k]);
			drive_bit(1'b1);
		end
	endtask

	task automatic receive_tx_byte(output uart_byte_t b);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (uart_tx_port !== 1'b0) begin
			if (n == 4 * cpb)
				report_timeout("start bit on uart_tx_port");
			n++;
			@(negedge sys_clk);
		end
		repeat (cpb / 2) @(negedge sys_clk);
		check_level(uart_tx_port, 1'b0, "start bit at mid bit");
		for (int k = 0; k < 8; k++) begin
			repeat (cpb) @(negedge sys_clk);
			b[k] = uart_tx_port;
		end
		repeat (cpb) @(negedge sys_clk);
		check_level(uart_tx_port, 1'b1, "stop bit at mid bit");
	endtask

	task automatic wait_tx_idle(input int limit);
		int n;
		n = 0;
		while (tx_busy !== 1'b0) begin
			if (n == limit)
				report_timeout("fall of tx_busy");
			n++;
			@(negedge sys_clk);
		end
	endtask

	task automatic wait_rx_idle(input int start_cnt, input bit need_done, input int limit);
		int n;
		n = 0;
		while (rx_busy !== 1'b0 || (need_done && rx_done_cnt == start_cnt)) begin
			if (n == limit)
				report_timeout(need_done ? "rx_done pulse" : "fall of rx_busy");
			n++;
			@(negedge sys_clk);
		end
	endtask

	task automatic run_tx_case(input string msg);
		ush_string_t m;
		uart_byte_t exp_q[$];
		uart_byte_t got;
		int start_cnt;
		m = make_string(msg);
		start_cnt = tx_done_cnt;
		@(posedge sys_clk);
		#1 tx_msg = m;
		tx_req = 1'b1;
		@(posedge sys_clk);
		// garbage after the request shows the message was latched
		#1 tx_req = 1'b0;
		tx_msg = '1;
		@(negedge sys_clk);
		if (msg.len() == 0) begin
			check_level(tx_busy, 1'b0, "tx_busy after zero length request");
			repeat (4 * 10 * cpb) begin
				@(negedge sys_clk);
				check_level(uart_tx_port, 1'b1, "uart_tx_port after zero length request");
			end
			check_level(tx_done_cnt == start_cnt, 1'b1, "no tx_done for zero length request");
		end else begin
			check_level(tx_busy, 1'b1, "tx_busy after request");
			exp_q = {open_char, open_char};
			for (int i = 0; i < msg.len(); i++)
				exp_q.push_back(msg[i]);
			exp_q.push_back(close_char);
			exp_q.push_back(close_char);
			foreach (exp_q[k]) begin
				receive_tx_byte(got);
				check_byte(got, exp_q[k], $sformatf("transmitted frame byte %0d", k));
			end
			wait_tx_idle(4 * cpb);
			check_level(tx_done_cnt == start_cnt + 1, 1'b1, "single tx_done pulse");
		end
	endtask

	task automatic run_rx_case(input string stim, input string exp_s, input bit stall);
		int start_cnt;
		start_cnt = rx_done_cnt;
		send_serial_string(stim);
		@(negedge sys_clk);
		if (stall) begin
			check_level(rx_busy, 1'b1, "rx_busy with an open frame");
			wait_rx_idle(start_cnt, 1'b0, `USH_RX_TIMEOUT + 10 * cpb);
			check_level(rx_done_cnt == start_cnt, 1'b1, "no rx_done after timeout");
		end else begin
			wait_rx_idle(start_cnt, 1'b1, 4 * cpb);
			check_level(rx_done_cnt == start_cnt + 1, 1'b1, "single rx_done pulse");
			check_string(rx_msg, make_string(exp_s), 1'b0, "received payload");
		end
	endtask

	initial begin
		sys_rst_n    = 1'b0;
		tx_req       = 1'b0;
		tx_msg       = '0;
		uart_rx_port = 1'b1;
		void'($urandom(32'h7345));

		set_case(0, case_tx, "hello", "");
		set_case(1, case_tx, "x}y", "");
		set_case(2, case_tx, "", "");
		set_case(3, case_rx, "{{uart ok}}", "uart ok");
		// junk and a lone open that the hunt throws away
		set_case(4, case_rx, "U{A{{junk first}}", "junk first");
		set_case(5, case_rx, "{{ab}cd}}", "ab}cd");
		set_case(6, case_rx_stall, "{{ab", "");
		set_case(7, case_rx, "{{after}}", "after");

		repeat (16) @(posedge sys_clk);
		#1 sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_level(tx_busy, 1'b0, "tx_busy after reset");
		check_level(tx_done, 1'b0, "tx_done after reset");
		check_level(rx_busy, 1'b0, "rx_busy after reset");
		check_level(rx_done, 1'b0, "rx_done after reset");
		check_level(uart_tx_port, 1'b1, "uart_tx_port after reset");
		check_string(rx_msg, '0, 1'b1, "rx_msg after reset");

		for (int c = 0; c < num_cases; c++) begin
			if (case_kind[c] == case_tx)
				run_tx_case(case_stim[c]);
			else
				run_rx_case(case_stim[c], case_exp[c], case_kind[c] == case_rx_stall);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire
